// File: rtl/cpuPkg.sv
//////////////////////////////////////////////////
// CPU package with the instruction layout, opcodes, ALU codes
// and the structs passed between pipeline stages
//////////////////////////////////////////////////
package cpuPkg;

    // Basic widths
    localparam int wordW = 32;
    localparam int regW  = 5;
    localparam int codeW = 5;

    typedef logic [wordW-1:0] word;
    typedef logic [regW-1:0]  regIdx;
    typedef logic [codeW-1:0] opcode;
    typedef logic [codeW-1:0] aluOp;
    typedef logic [wordW-1:0] instr;

    // Upper bit of each instruction field
    localparam int opHi     = 31;
    localparam int rdHi     = 26;
    localparam int rsHi     = 21;
    localparam int rtHi     = 16;
    localparam int shamtHi  = 11;
    localparam int aluOpHi  = 6;
    localparam int immHi    = 16;
    localparam int targetHi = 26;

    // Primary opcodes
    localparam opcode opAlu  = 5'd0;
    localparam opcode opJ    = 5'd1;
    localparam opcode opBne  = 5'd2;
    localparam opcode opJal  = 5'd3;
    localparam opcode opJr   = 5'd4;
    localparam opcode opAddi = 5'd5;
    localparam opcode opBlt  = 5'd6;
    localparam opcode opSw   = 5'd7;
    localparam opcode opLw   = 5'd8;

    // ALU function codes for R-type
    localparam aluOp aluAdd = 5'd0;
    localparam aluOp aluSub = 5'd1;
    localparam aluOp aluAnd = 5'd2;
    localparam aluOp aluOr  = 5'd3;
    localparam aluOp aluSll = 5'd4;
    localparam aluOp aluSra = 5'd5;

    localparam regIdx zeroReg = 5'd0;
    localparam regIdx linkReg = 5'd31;

    //////////////////////////////////////////////////
    // Pipeline registers, all-zero is a bubble
    //////////////////////////////////////////////////
    typedef struct packed {
        instr ir;
        word  pcNext;
    } fdReg;

    typedef struct packed {
        instr ir;
        word  pcNext;
        word  dataA;
        // Second operand is rd or rt, picked in decode
        word  dataB;
    } dxReg;

    typedef struct packed {
        instr ir;
        word  result;
        word  storeData;
    } xmReg;

    typedef struct packed {
        instr ir;
        word  result;
        word  loadData;
    } mwReg;

    //////////////////////////////////////////////////
    // Ports and side paths
    //////////////////////////////////////////////////
    typedef struct packed {
        regIdx regA;
        regIdx regB;
    } regReadReq;

    typedef struct packed {
        logic  enable;
        regIdx dest;
        word   data;
    } regWriteReq;

    typedef struct packed {
        word  address;
        word  writeData;
        logic wren;
    } dmemReq;

    typedef struct packed {
        logic taken;
        word  target;
    } redirect;

    typedef struct packed {
        logic  valid;
        regIdx dest;
        word   value;
    } bypassSrc;

    // Field extraction
    function automatic opcode opOf(input instr ir);
        return ir[opHi -: codeW];
    endfunction

    function automatic regIdx rdOf(input instr ir);
        return ir[rdHi -: regW];
    endfunction

    function automatic regIdx rsOf(input instr ir);
        return ir[rsHi -: regW];
    endfunction

    function automatic regIdx rtOf(input instr ir);
        return ir[rtHi -: regW];
    endfunction

    function automatic logic [regW-1:0] shamtOf(input instr ir);
        return ir[shamtHi -: regW];
    endfunction

    function automatic aluOp funcOf(input instr ir);
        return ir[aluOpHi -: codeW];
    endfunction

    // Immediate is signed
    function automatic word immOf(input instr ir);
        return {{(wordW - immHi - 1){ir[immHi]}}, ir[immHi:0]};
    endfunction

    // Jump target is zero-extended
    function automatic word targetOf(input instr ir);
        return {{(wordW - targetHi - 1){1'b0}}, ir[targetHi:0]};
    endfunction

    // jal links into r31, everything else names rd
    function automatic regIdx destReg(input instr ir);
        return (opOf(ir) == opJal) ? linkReg : rdOf(ir);
    endfunction

    // r0 targets count as no write, so bubbles stay silent
    function automatic logic writesReg(input instr ir);
        return (opOf(ir) inside {opAlu, opAddi, opLw, opJal}) && (destReg(ir) != zeroReg);
    endfunction

endpackage

// File: rtl/alu.sv
//////////////////////////////////////////////////
// ALU, add/sub/logic/shift with signed compare flags
//////////////////////////////////////////////////
module alu (
    input  cpuPkg::word   a,
    input  cpuPkg::word   b,
    input  cpuPkg::aluOp  op,
    input  logic [4:0]    shamt,
    output cpuPkg::word   result,
    output logic          notEqual,
    output logic          lessThan
);

    cpuPkg::word diff;
    logic        overflow;

    // Subtractor shared by sub and the compares
    assign diff = a - b;

    // Signs differ and the difference flipped away from a
    assign overflow = (a[31] ^ b[31]) & (diff[31] ^ a[31]);

    assign notEqual = |diff;
    // Signed a < b, corrected for overflow
    assign lessThan = diff[31] ^ overflow;

    always_comb begin
        case (op)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = diff;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluSll: result = a << shamt;
            // Arithmetic shift keeps the sign
            cpuPkg::aluSra: result = $signed(a) >>> shamt;
            default:        result = '0;
        endcase
    end

endmodule

// File: rtl/fetchStage.sv
//////////////////////////////////////////////////
// Fetch stage holding the program counter
// and selecting the next PC
//////////////////////////////////////////////////
module fetchStage (
    input  logic             clock,
    input  logic             rst,
    input  logic             stall,
    input  cpuPkg::redirect  redir,
    output cpuPkg::word      pc,
    output cpuPkg::word      pcNext
);

    // Sequential successor that also travels down the pipe for jal and branches
    assign pcNext = pc + 32'd1;

    // Redirect beats stall and a stall holds the PC
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (redir.taken) begin
            pc <= redir.target;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Only a branch or jump in execute redirects and only a load there stalls
    redirNotStalled: assert property (
        @(posedge clock) disable iff (rst)
        redir.taken |-> !stall
    );

endmodule

// File: rtl/decodeStage.sv
//////////////////////////////////////////////////
// Decode stage holding the FD register, selecting the
// register-file reads and detecting load-use hazards
//////////////////////////////////////////////////
module decodeStage (
    input  logic               clock,
    input  logic               rst,
    input  cpuPkg::instr       fetchInstr,
    input  cpuPkg::word        fetchPcNext,
    output logic               stall,
    input  cpuPkg::redirect    redir,
    input  cpuPkg::instr       dxInstr,
    output cpuPkg::regReadReq  readReq,
    output cpuPkg::fdReg       fd
);

    cpuPkg::opcode fdOp;
    cpuPkg::regIdx regA;
    cpuPkg::regIdx regB;
    cpuPkg::regIdx dxDest;
    logic          usesRd;

    // FD register
    // Flushed by a taken redirect and frozen by a load-use stall
    always_ff @(posedge clock) begin
        if (rst || redir.taken) begin
            fd <= '0;
        end else if (!stall) begin
            fd <= '{ir: fetchInstr, pcNext: fetchPcNext};
        end
    end

    assign fdOp = cpuPkg::opOf(fd.ir);

    // Branches, jr and sw read rd on port B
    assign usesRd = fdOp inside {cpuPkg::opBne, cpuPkg::opBlt, cpuPkg::opJr, cpuPkg::opSw};

    assign regA = cpuPkg::rsOf(fd.ir);
    assign regB = usesRd ? cpuPkg::rdOf(fd.ir) : cpuPkg::rtOf(fd.ir);

    assign readReq = '{regA: regA, regB: regB};

    //////////////////////////////////////////////////
    // Load-use hazard
    //////////////////////////////////////////////////

    // Destination of the load sitting in execute
    assign dxDest = cpuPkg::rdOf(dxInstr);

    // sw store data is patched later in memory so only its address needs the wait
    assign stall = (cpuPkg::opOf(dxInstr) == cpuPkg::opLw) &&
                   ((dxDest == regA) || ((dxDest == regB) && (fdOp != cpuPkg::opSw)));

    // The bubble that execute takes on a stall releases decode a cycle later
    stallOneCycle: assert property (
        @(posedge clock) disable iff (rst)
        stall |=> !stall
    );

endmodule

// File: rtl/executeStage.sv
//////////////////////////////////////////////////
// Execute stage holding the DX register, bypassing
// operands and resolving branches and jumps
//////////////////////////////////////////////////
module executeStage (
    input  logic              clock,
    input  logic              rst,
    input  cpuPkg::fdReg      fd,
    input  cpuPkg::word       readDataA,
    input  cpuPkg::word       readDataB,
    input  cpuPkg::regIdx     readRegB,
    input  logic              stall,
    input  cpuPkg::bypassSrc  memFwd,
    input  cpuPkg::bypassSrc  wbFwd,
    output cpuPkg::redirect   redir,
    output cpuPkg::xmReg      xmNext,
    output cpuPkg::instr      dxInstr
);

    cpuPkg::dxReg  dx;
    cpuPkg::regIdx dxRegB;
    cpuPkg::opcode dxOp;
    cpuPkg::word   opA;
    cpuPkg::word   opB;
    cpuPkg::word   imm;
    cpuPkg::word   aluA;
    cpuPkg::word   aluB;
    cpuPkg::word   aluOut;
    cpuPkg::aluOp  aluFn;
    logic          isBranch;
    logic          useImm;
    logic          notEqual;
    logic          lessThan;

    // Newest producer wins with memory over writeback over the register file
    function automatic cpuPkg::word bypass(input cpuPkg::regIdx src,
                                           input cpuPkg::word regData,
                                           input cpuPkg::bypassSrc mem,
                                           input cpuPkg::bypassSrc wb);
        cpuPkg::word value;
        value = regData;
        if ((src != cpuPkg::zeroReg) && wb.valid && (wb.dest == src)) begin
            value = wb.value;
        end
        if ((src != cpuPkg::zeroReg) && mem.valid && (mem.dest == src)) begin
            value = mem.value;
        end
        return value;
    endfunction

    // DX register
    // Bubble on flush or on the load-use stall
    always_ff @(posedge clock) begin
        if (rst || redir.taken || stall) begin
            dx     <= '0;
            dxRegB <= '0;
        end else begin
            dx     <= '{ir: fd.ir, pcNext: fd.pcNext, dataA: readDataA, dataB: readDataB};
            dxRegB <= readRegB;
        end
    end

    assign dxOp    = cpuPkg::opOf(dx.ir);
    assign dxInstr = dx.ir;

    //////////////////////////////////////////////////
    // Operands
    //////////////////////////////////////////////////
    assign opA = bypass(cpuPkg::rsOf(dx.ir), dx.dataA, memFwd, wbFwd);
    assign opB = bypass(dxRegB, dx.dataB, memFwd, wbFwd);
    assign imm = cpuPkg::immOf(dx.ir);

    assign isBranch = dxOp inside {cpuPkg::opBne, cpuPkg::opBlt};
    assign useImm   = dxOp inside {cpuPkg::opAddi, cpuPkg::opLw, cpuPkg::opSw};

    // Branches put rd on the left so blt tests rd < rs
    assign aluA  = isBranch ? opB : opA;
    assign aluB  = isBranch ? opA : (useImm ? imm : opB);
    assign aluFn = isBranch ? cpuPkg::aluSub : (useImm ? cpuPkg::aluAdd : cpuPkg::funcOf(dx.ir));

    alu alu_i (
        .a        (aluA),
        .b        (aluB),
        .op       (aluFn),
        .shamt    (cpuPkg::shamtOf(dx.ir)),
        .result   (aluOut),
        .notEqual (notEqual),
        .lessThan (lessThan)
    );

    //////////////////////////////////////////////////
    // Control flow
    //////////////////////////////////////////////////
    always_comb begin
        redir = '0;
        case (dxOp)
            cpuPkg::opBne: begin
                redir.taken  = notEqual;
                redir.target = dx.pcNext + imm;
            end
            cpuPkg::opBlt: begin
                redir.taken  = lessThan;
                redir.target = dx.pcNext + imm;
            end
            cpuPkg::opJ, cpuPkg::opJal: begin
                redir.taken  = 1'b1;
                redir.target = cpuPkg::targetOf(dx.ir);
            end
            // jr jumps to rd as read on port B
            cpuPkg::opJr: begin
                redir.taken  = 1'b1;
                redir.target = opB;
            end
            default: redir = '0;
        endcase
    end

    // jal carries its return address as the result
    assign xmNext = '{ir:        dx.ir,
                      result:    (dxOp == cpuPkg::opJal) ? dx.pcNext : aluOut,
                      storeData: opB};

endmodule

// File: rtl/memoryStage.sv
//////////////////////////////////////////////////
// Memory stage, XM register and data-memory request
//////////////////////////////////////////////////
module memoryStage (
    input  logic              clock,
    input  logic              rst,
    input  cpuPkg::xmReg      xmNext,
    input  cpuPkg::bypassSrc  wbFwd,
    output cpuPkg::dmemReq    dmem,
    input  cpuPkg::word       loadData,
    output cpuPkg::bypassSrc  memFwd,
    output cpuPkg::mwReg      mwNext
);

    cpuPkg::xmReg xm;
    logic         storeBypass;

    // XM register
    always_ff @(posedge clock) begin
        if (rst) begin
            xm <= '0;
        end else begin
            xm <= xmNext;
        end
    end

    // Store data may come from a load that has just reached writeback
    assign storeBypass = wbFwd.valid && (wbFwd.dest == cpuPkg::rdOf(xm.ir));

    // Address is the ALU sum, write only for sw
    assign dmem = '{address:   xm.result,
                    writeData: storeBypass ? wbFwd.value : xm.storeData,
                    wren:      cpuPkg::opOf(xm.ir) == cpuPkg::opSw};

    // Bypass source for execute
    // Load data is not back yet, the load-use stall covers that case
    assign memFwd = '{valid: cpuPkg::writesReg(xm.ir),
                      dest:  cpuPkg::destReg(xm.ir),
                      value: xm.result};

    assign mwNext = '{ir: xm.ir, result: xm.result, loadData: loadData};

endmodule

// File: rtl/writebackStage.sv
//////////////////////////////////////////////////
// Writeback stage, MW register and register-file write
//////////////////////////////////////////////////
module writebackStage (
    input  logic                clock,
    input  logic                rst,
    input  cpuPkg::mwReg        mwNext,
    output cpuPkg::regWriteReq  regWrite,
    output cpuPkg::bypassSrc    wbFwd
);

    cpuPkg::mwReg mw;
    cpuPkg::word  wbData;

    // MW register
    always_ff @(posedge clock) begin
        if (rst) begin
            mw <= '0;
        end else begin
            mw <= mwNext;
        end
    end

    // Loads write memory data, the rest write the result
    assign wbData = (cpuPkg::opOf(mw.ir) == cpuPkg::opLw) ? mw.loadData : mw.result;

    assign regWrite = '{enable: cpuPkg::writesReg(mw.ir),
                        dest:   cpuPkg::destReg(mw.ir),
                        data:   wbData};

    // Same value the register file gets this cycle
    assign wbFwd = '{valid: regWrite.enable, dest: regWrite.dest, value: regWrite.data};

endmodule

// File: rtl/processor.sv
//////////////////////////////////////////////////
// Five-stage pipelined core, memories and register file outside
//////////////////////////////////////////////////
module processor (
    input  logic                clock,
    input  logic                rst,
    // Instruction memory
    output cpuPkg::word         addressImem,
    input  cpuPkg::instr        qImem,
    // Data memory
    output cpuPkg::dmemReq      dmem,
    input  cpuPkg::word         qDmem,
    // Register file
    output cpuPkg::regReadReq   readReq,
    input  cpuPkg::word         dataReadA,
    input  cpuPkg::word         dataReadB,
    output cpuPkg::regWriteReq  regWrite
);

    cpuPkg::word      pcNext;
    logic             stall;
    cpuPkg::redirect  redir;
    cpuPkg::fdReg     fd;
    cpuPkg::instr     dxInstr;
    cpuPkg::xmReg     xmNext;
    cpuPkg::mwReg     mwNext;
    cpuPkg::bypassSrc memFwd;
    cpuPkg::bypassSrc wbFwd;

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    // PC goes straight out as the imem address
    fetchStage fetch_i (
        .clock  (clock),
        .rst    (rst),
        .stall  (stall),
        .redir  (redir),
        .pc     (addressImem),
        .pcNext (pcNext)
    );

    decodeStage decode_i (
        .clock       (clock),
        .rst         (rst),
        .fetchInstr  (qImem),
        .fetchPcNext (pcNext),
        .stall       (stall),
        .redir       (redir),
        .dxInstr     (dxInstr),
        .readReq     (readReq),
        .fd          (fd)
    );

    // Register data arrives the same cycle and is captured into DX
    executeStage execute_i (
        .clock     (clock),
        .rst       (rst),
        .fd        (fd),
        .readDataA (dataReadA),
        .readDataB (dataReadB),
        .readRegB  (readReq.regB),
        .stall     (stall),
        .memFwd    (memFwd),
        .wbFwd     (wbFwd),
        .redir     (redir),
        .xmNext    (xmNext),
        .dxInstr   (dxInstr)
    );

    memoryStage memory_i (
        .clock    (clock),
        .rst      (rst),
        .xmNext   (xmNext),
        .wbFwd    (wbFwd),
        .dmem     (dmem),
        .loadData (qDmem),
        .memFwd   (memFwd),
        .mwNext   (mwNext)
    );

    writebackStage writeback_i (
        .clock    (clock),
        .rst      (rst),
        .mwNext   (mwNext),
        .regWrite (regWrite),
        .wbFwd    (wbFwd)
    );

endmodule

// File: tb/programTable.svh
//////////////////////////////////////////////////
// Test programs and the register writes each must produce
//////////////////////////////////////////////////
task automatic buildTable();

    // Dependent chain, bypass from memory and writeback, r0 writes
    beginEntry(0, "alu chain");
    emit(iType(cpuPkg::opAddi, 1, 0, 5));
    emit(iType(cpuPkg::opAddi, 2, 1, 3));
    emit(rType(cpuPkg::aluAdd, 3, 2, 1, 0));
    emit(rType(cpuPkg::aluSub, 4, 3, 1, 0));
    emit(rType(cpuPkg::aluSll, 5, 4, 0, 2));
    emit(rType(cpuPkg::aluOr, 6, 5, 3, 0));
    emit(iType(cpuPkg::opAddi, 7, 0, -64));
    emit(rType(cpuPkg::aluSra, 8, 7, 0, 3));
    emit(rType(cpuPkg::aluAnd, 9, 6, 8, 0));
    // Write to r0 must not feed the next read of r0
    emit(rType(cpuPkg::aluAdd, 0, 9, 9, 0));
    emit(rType(cpuPkg::aluSub, 10, 9, 0, 0));
    emit(iType(cpuPkg::opAddi, 0, 0, 7));
    emit(iType(cpuPkg::opAddi, 11, 0, 1));
    emit(jType(cpuPkg::opJ, curAddr));
    want(1, 5);
    want(2, 8);
    want(3, 13);
    want(4, 8);
    want(5, 32);
    want(6, 45);
    want(7, -64);
    want(8, -8);
    want(9, 40);
    want(10, 40);
    want(11, 1);

    // Store then load, load-use stalls, store data from a fresh load
    beginEntry(1, "load store");
    emit(iType(cpuPkg::opAddi, 1, 0, 20));
    emit(iType(cpuPkg::opAddi, 2, 0, 77));
    emit(iType(cpuPkg::opSw, 2, 1, 4));
    emit(iType(cpuPkg::opLw, 3, 1, 4));
    emit(rType(cpuPkg::aluAdd, 4, 3, 2, 0));
    emit(iType(cpuPkg::opLw, 5, 1, 4));
    emit(iType(cpuPkg::opSw, 5, 1, 8));
    emit(iType(cpuPkg::opLw, 6, 1, 8));
    emit(iType(cpuPkg::opAddi, 7, 6, -7));
    emit(jType(cpuPkg::opJ, curAddr));
    want(1, 20);
    want(2, 77);
    want(3, 77);
    want(4, 154);
    want(5, 77);
    want(6, 77);
    want(7, 70);

    // bne and blt both ways, skipped slots hold r4, r5, r7, r8 writes
    beginEntry(2, "branches");
    emit(iType(cpuPkg::opAddi, 1, 0, 3));
    emit(iType(cpuPkg::opAddi, 2, 0, 5));
    emit(iType(cpuPkg::opBne, 1, 1, 2));
    emit(iType(cpuPkg::opAddi, 3, 0, 11));
    emit(iType(cpuPkg::opBne, 1, 2, 2));
    emit(iType(cpuPkg::opAddi, 4, 0, 99));
    emit(iType(cpuPkg::opAddi, 5, 0, 99));
    // Target of the taken bne, 5 < 3 is false
    emit(iType(cpuPkg::opBlt, 2, 1, 2));
    emit(iType(cpuPkg::opAddi, 6, 0, -4));
    // Signed -4 < 0, lands on 12
    emit(iType(cpuPkg::opBlt, 6, 0, 2));
    emit(iType(cpuPkg::opAddi, 7, 0, 99));
    emit(iType(cpuPkg::opAddi, 8, 0, 99));
    emit(iType(cpuPkg::opAddi, 9, 6, 10));
    emit(jType(cpuPkg::opJ, curAddr));
    want(1, 3);
    want(2, 5);
    want(3, 11);
    want(6, -4);
    want(9, 6);

    // jal into a subroutine at 6, jr back to 2, j over 4 to 8
    beginEntry(3, "jumps");
    emit(iType(cpuPkg::opAddi, 1, 0, 1));
    emit(jType(cpuPkg::opJal, 6));
    emit(iType(cpuPkg::opAddi, 2, 1, 1));
    emit(jType(cpuPkg::opJ, 9));
    emit(iType(cpuPkg::opAddi, 3, 0, 99));
    emit(iType(cpuPkg::opAddi, 4, 0, 99));
    emit(iType(cpuPkg::opAddi, 5, 0, 50));
    emit(iType(cpuPkg::opJr, 31, 0, 0));
    emit(iType(cpuPkg::opAddi, 6, 0, 99));
    emit(rType(cpuPkg::aluAdd, 7, 5, 2, 0));
    emit(jType(cpuPkg::opJ, curAddr));
    want(1, 1);
    want(31, 2);
    want(5, 50);
    want(2, 2);
    want(7, 52);

    // Backward bne, sums 3 + 2 + 1
    beginEntry(4, "backward loop");
    emit(iType(cpuPkg::opAddi, 1, 0, 3));
    emit(iType(cpuPkg::opAddi, 2, 0, 0));
    emit(rType(cpuPkg::aluAdd, 2, 2, 1, 0));
    emit(iType(cpuPkg::opAddi, 1, 1, -1));
    emit(iType(cpuPkg::opBne, 1, 0, -3));
    emit(iType(cpuPkg::opAddi, 3, 2, 100));
    emit(jType(cpuPkg::opJ, curAddr));
    want(1, 3);
    want(2, 0);
    want(2, 3);
    want(1, 2);
    want(2, 5);
    want(1, 1);
    want(2, 6);
    want(1, 0);
    want(3, 106);

endtask

// File: tb/processorTb.sv
//////////////////////////////////////////////////
// Testbench for the pipelined core with memory and
// register-file models and table-driven programs
//////////////////////////////////////////////////
module processorTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 10;
    localparam int runCycles   = 40;
    localparam int numTests    = 5;
    localparam int maxWords    = 16;

    logic                clock;
    logic                rst;
    cpuPkg::word         addressImem;
    cpuPkg::instr        qImem;
    cpuPkg::dmemReq      dmem;
    cpuPkg::word         qDmem;
    cpuPkg::regReadReq   readReq;
    cpuPkg::word         dataReadA;
    cpuPkg::word         dataReadB;
    cpuPkg::regWriteReq  regWrite;

    // Memory and register-file models
    bit [31:0] imem [64];
    bit [31:0] dmemArr [256];
    bit [31:0] regs [32];

    // Test table, filled by buildTable
    string              testName [numTests];
    cpuPkg::instr       progWords [numTests][maxWords];
    int                 wantCount [numTests];
    cpuPkg::regWriteReq wantWrites [numTests][maxWords];
    int                 curTest;
    int                 curAddr;

    // Writes seen during one program run
    cpuPkg::regWriteReq seen [$];
    int                 testErrs;
    int                 passCount;
    int                 failCount;

    processor dut_i (
        .clock       (clock),
        .rst         (rst),
        .addressImem (addressImem),
        .qImem       (qImem),
        .dmem        (dmem),
        .qDmem       (qDmem),
        .readReq     (readReq),
        .dataReadA   (dataReadA),
        .dataReadB   (dataReadB),
        .regWrite    (regWrite)
    );

    always #(clkPeriod / 2) clock = ~clock;

    //////////////////////////////////////////////////
    // Models
    //////////////////////////////////////////////////

    // Combinational reads, same cycle
    assign qImem = imem[addressImem[5:0]];
    assign qDmem = dmemArr[dmem.address[7:0]];

    // Write-first register file, r0 reads zero
    assign dataReadA = (readReq.regA == '0) ? '0 :
                       (regWrite.enable && (regWrite.dest == readReq.regA)) ? regWrite.data :
                       regs[readReq.regA];
    assign dataReadB = (readReq.regB == '0) ? '0 :
                       (regWrite.enable && (regWrite.dest == readReq.regB)) ? regWrite.data :
                       regs[readReq.regB];

    // Reset clears data memory and registers
    always @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            for (int i = 0; i < 256; i++) begin
                dmemArr[i] <= '0;
            end
        end else begin
            if (regWrite.enable && (regWrite.dest != '0)) begin
                regs[regWrite.dest] <= regWrite.data;
            end
            if (dmem.wren) begin
                dmemArr[dmem.address[7:0]] <= dmem.writeData;
            end
        end
    end

    //////////////////////////////////////////////////
    // Instruction encoding and table building
    //////////////////////////////////////////////////
    function automatic cpuPkg::instr rType(input cpuPkg::aluOp fn, input int rd,
                                           input int rs, input int rt, input int sh);
        return {cpuPkg::opAlu, rd[4:0], rs[4:0], rt[4:0], sh[4:0], fn, 2'b00};
    endfunction

    // Immediate forms: addi, lw, sw, bne, blt, jr
    function automatic cpuPkg::instr iType(input cpuPkg::opcode op, input int rd,
                                           input int rs, input int imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic cpuPkg::instr jType(input cpuPkg::opcode op, input int target);
        return {op, target[26:0]};
    endfunction

    task automatic beginEntry(input int idx, input string name);
        curTest        = idx;
        curAddr        = 0;
        testName[idx]  = name;
        wantCount[idx] = 0;
        for (int i = 0; i < maxWords; i++) begin
            progWords[idx][i] = '0;
        end
    endtask

    task automatic emit(input cpuPkg::instr w);
        progWords[curTest][curAddr] = w;
        curAddr++;
    endtask

    task automatic want(input int r, input int v);
        wantWrites[curTest][wantCount[curTest]] = '{enable: 1'b1, dest: r[4:0], data: v};
        wantCount[curTest]++;
    endtask

    `include "programTable.svh"

    //////////////////////////////////////////////////
    // Test steps
    //////////////////////////////////////////////////

    // Hold reset, load the program, check the core stays idle
    task automatic resetCore(input int t);
        @(posedge clock);
        #1;
        rst = 1'b1;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < maxWords; i++) begin
            imem[i] = progWords[t][i];
        end
        repeat (resetCycles) begin
            @(posedge clock);
            #1;
            assert (!regWrite.enable && !dmem.wren && (addressImem == '0)) else begin
                $display("ERR %0t: core active while reset is held, pc %h", $time, addressImem);
                testErrs++;
            end
        end
        rst = 1'b0;
    endtask

    task automatic checkWrites(input int t);
        int common;
        common = (seen.size() < wantCount[t]) ? seen.size() : wantCount[t];
        for (int i = 0; i < common; i++) begin
            assert (seen[i] == wantWrites[t][i]) else begin
                $display("ERR %0t: %s write %0d is r%0d = %h, expected r%0d = %h",
                         $time, testName[t], i, seen[i].dest, seen[i].data,
                         wantWrites[t][i].dest, wantWrites[t][i].data);
                testErrs++;
            end
        end
        assert (seen.size() >= wantCount[t]) else begin
            $display("%s: only %0d of the %0d expected register writes happened",
                     testName[t], seen.size(), wantCount[t]);
            testErrs++;
        end
        assert (seen.size() <= wantCount[t]) else begin
            $display("%s: %0d register writes happened, more than the %0d expected",
                     testName[t], seen.size(), wantCount[t]);
            testErrs++;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        clock     = 1'b0;
        rst       = 1'b1;
        passCount = 0;
        failCount = 0;
        buildTable();
        for (int t = 0; t < numTests; t++) begin
            testErrs = 0;
            resetCore(t);
            seen.delete();
            // Sample after the edge, each write once
            repeat (runCycles) begin
                @(posedge clock);
                #1;
                if (regWrite.enable) begin
                    seen.push_back(regWrite);
                end
            end
            checkWrites(t);
            if (testErrs == 0) begin
                passCount++;
                $display("PASS %s, %0d writes", testName[t], seen.size());
            end else begin
                failCount++;
                $display("FAIL %s, %0d errors", testName[t], testErrs);
            end
        end
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog, 60 cycles per table entry
    initial begin
        #(numTests * 60 * clkPeriod);
        $display("Watchdog: tests did not finish within %0d ns", numTests * 60 * clkPeriod);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: processor.f
+incdir+tb
rtl/cpuPkg.sv
rtl/alu.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/writebackStage.sv
rtl/processor.sv
tb/processorTb.sv

// File: Makefile
# Verilator build and run for the pipelined core testbench

compile: obj_dir/VprocessorTb

obj_dir/VprocessorTb: processor.f rtl/*.sv tb/processorTb.sv tb/programTable.svh
	verilator --binary --timing --assert --top-module processorTb -f processor.f -o VprocessorTb

run: obj_dir/VprocessorTb
	./obj_dir/VprocessorTb > sim.log 2>&1; cat sim.log
	@if grep -q "Regression failed" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean
